// File: rtl/mac_pkg.sv
// ################################################
// shared opcodes, widths and selector types of the MAC block
// imported by decode, pipeline, result stage and top level
// ################################################

package mac_pkg;

	// command operand and tag widths
	localparam int OPER_W = 16;
	localparam int TAG_W  = 4;

	// datapath widths, multiplier inputs follow a DSP slice port
	localparam int MUL_W = 18;
	localparam int ACC_W = 48;
	localparam int SAT_W = 32;

	// command opcodes
	typedef enum logic [2:0] {
		OP_MUL_S = 3'd0, // acc = a * b, signed
		OP_MUL_U = 3'd1, // acc = a * b, unsigned
		OP_MAC_S = 3'd2, // acc += a * b, signed
		OP_MAC_U = 3'd3, // acc += a * b, unsigned
		OP_MSU_S = 3'd4, // acc -= a * b, signed
		OP_LOAD  = 3'd5  // acc = sext({a, b})
	} mac_op_t;

	// post-adder operand select
	typedef enum logic {
		SEL_ADDEND = 1'b0, // fresh addend from decode
		SEL_ACC    = 1'b1  // feedback from output register
	} post_sel_t;

endpackage

// File: rtl/mac_op_decode.sv
// ################################################
// combinational decode of a MAC command into operand extension,
// addend and post-adder controls for mac16x16
// ################################################

module mac_op_decode import mac_pkg::*; (
	input  logic              cmd_valid,
	input  mac_op_t           cmd_op,
	input  logic [OPER_W-1:0] cmd_a,
	input  logic [OPER_W-1:0] cmd_b,
	output logic [MUL_W-1:0]  mul_a,
	output logic [MUL_W-1:0]  mul_b,
	output logic [ACC_W-1:0]  addend,
	output post_sel_t         post_sel,
	output logic              sub,
	output logic              acc_en
);

	logic                  sign_ext;   // sign or zero extension of operands
	logic                  mul_zero;   // load forces the product to zero
	logic [MUL_W-1:0]      a_ext;
	logic [MUL_W-1:0]      b_ext;
	logic [ACC_W-1:0]      load_val;

	// extension of the 16-bit operands up to the multiplier width
	assign a_ext = {{(MUL_W-OPER_W){sign_ext & cmd_a[OPER_W-1]}}, cmd_a};
	assign b_ext = {{(MUL_W-OPER_W){sign_ext & cmd_b[OPER_W-1]}}, cmd_b};

	// a is the high half, b the low half, sign taken from a
	assign load_val = {{(ACC_W-2*OPER_W){cmd_a[OPER_W-1]}}, cmd_a, cmd_b};

	always_comb begin
		sign_ext = 1'b0;
		mul_zero = 1'b0;
		post_sel = SEL_ADDEND;
		sub      = 1'b0;
		addend   = '0;
		unique case (cmd_op)
			OP_MUL_S: begin
				sign_ext = 1'b1;
			end
			OP_MUL_U: begin
				sign_ext = 1'b0;
			end
			OP_MAC_S: begin
				sign_ext = 1'b1;
				post_sel = SEL_ACC;
			end
			OP_MAC_U: begin
				post_sel = SEL_ACC;
			end
			OP_MSU_S: begin
				sign_ext = 1'b1;
				post_sel = SEL_ACC;
				sub      = 1'b1;
			end
			OP_LOAD: begin
				mul_zero = 1'b1;
				addend   = load_val;
			end
			default: begin
				// unused codes behave like an unsigned multiply
				sign_ext = 1'b0;
			end
		endcase
	end

	// product forced to zero on a load
	always_comb begin
		if (mul_zero) begin
			mul_a = '0;
			mul_b = '0;
		end else begin
			mul_a = a_ext;
			mul_b = b_ext;
		end
	end

	assign acc_en = cmd_valid; // every command updates the accumulator

endmodule

// File: rtl/mac16x16.sv
// ################################################
// pipelined 18x18 signed multiplier with 48-bit post-adder
// accumulator feedback comes from the output register
// latency INPUT_REG + MUL_REG + 1 from inputs to acc_out
// ################################################

module mac16x16 import mac_pkg::*; #(
	parameter int INPUT_REG = 1,
	parameter int MUL_REG   = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             acc_en,
	input  logic [MUL_W-1:0] mul_a,
	input  logic [MUL_W-1:0] mul_b,
	input  logic [ACC_W-1:0] addend,
	input  post_sel_t        post_sel,
	input  logic             sub,
	output logic [ACC_W-1:0] acc_out
);

	// stage 1, after the optional input register
	logic [MUL_W-1:0]        a_1;
	logic [MUL_W-1:0]        b_1;
	logic [ACC_W-1:0]        addend_1;
	post_sel_t               sel_1;
	logic                    sub_1;
	logic                    en_1;
	logic signed [2*MUL_W-1:0] prod_1;

	// stage 2, after the optional product register
	logic signed [2*MUL_W-1:0] prod_2;
	logic [ACC_W-1:0]        addend_2;
	post_sel_t               sel_2;
	logic                    sub_2;
	logic                    en_2;

	logic [ACC_W-1:0]        prod_ext;
	logic [ACC_W-1:0]        acc_base;
	logic [ACC_W-1:0]        acc_q;

	generate
		if (INPUT_REG != 0) begin : g_in_reg
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					en_1 <= 1'b0;
				end else begin
					en_1 <= acc_en;
				end
			end
			always_ff @(posedge clk) begin
				a_1      <= mul_a;
				b_1      <= mul_b;
				addend_1 <= addend;
				sel_1    <= post_sel;
				sub_1    <= sub;
			end
		end else begin : g_in_comb
			assign en_1     = acc_en;
			assign a_1      = mul_a;
			assign b_1      = mul_b;
			assign addend_1 = addend;
			assign sel_1    = post_sel;
			assign sub_1    = sub;
		end
	endgenerate

	// operands already extended, so one signed multiply covers both kinds
	assign prod_1 = $signed(a_1) * $signed(b_1);

	generate
		if (MUL_REG != 0) begin : g_mul_reg
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					en_2 <= 1'b0;
				end else begin
					en_2 <= en_1;
				end
			end
			always_ff @(posedge clk) begin
				prod_2   <= prod_1;
				addend_2 <= addend_1; // delayed alongside, like the C port
				sel_2    <= sel_1;
				sub_2    <= sub_1;
			end
		end else begin : g_mul_comb
			assign en_2     = en_1;
			assign prod_2   = prod_1;
			assign addend_2 = addend_1;
			assign sel_2    = sel_1;
			assign sub_2    = sub_1;
		end
	endgenerate

	assign prod_ext = {{(ACC_W-2*MUL_W){prod_2[2*MUL_W-1]}}, prod_2};
	assign acc_base = (sel_2 == SEL_ACC) ? acc_q : addend_2;

	// post-adder and accumulator, idle cycles hold the value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_q <= '0;
		end else if (en_2) begin
			acc_q <= sub_2 ? (acc_base - prod_ext) : (acc_base + prod_ext);
		end
	end

	assign acc_out = acc_q;

endmodule

// File: rtl/acc_result_stage.sv
// ################################################
// result side of the MAC, valid and tag delay line matched
// to the pipeline, plus signed 32-bit saturation of acc_out
// ################################################

module acc_result_stage import mac_pkg::*; #(
	parameter int INPUT_REG = 1,
	parameter int MUL_REG   = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cmd_valid,
	input  logic [TAG_W-1:0] cmd_tag,
	input  logic [ACC_W-1:0] acc_out,
	output logic             res_valid,
	output logic [TAG_W-1:0] res_tag,
	output logic [ACC_W-1:0] res_acc,
	output logic [SAT_W-1:0] res_sat
);

	// same depth as mac16x16
	localparam int LATENCY = INPUT_REG + MUL_REG + 1;

	logic [LATENCY-1:0]           vld_sr;
	logic [LATENCY-1:0][TAG_W-1:0] tag_sr;
	logic [ACC_W-SAT_W:0]         upper;  // bits that must all match the sign

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr[0] <= cmd_valid;
			for (int i = 1; i < LATENCY; i++) begin
				vld_sr[i] <= vld_sr[i-1];
			end
		end
	end

	// tags ride along without reset, qualified by vld_sr
	always_ff @(posedge clk) begin
		tag_sr[0] <= cmd_tag;
		for (int i = 1; i < LATENCY; i++) begin
			tag_sr[i] <= tag_sr[i-1];
		end
	end

	assign res_valid = vld_sr[LATENCY-1];
	assign res_tag   = tag_sr[LATENCY-1];
	assign res_acc   = acc_out; // already registered in the post-adder

	assign upper = acc_out[ACC_W-1:SAT_W-1];

	always_comb begin
		if (&upper || ~|upper) begin
			res_sat = acc_out[SAT_W-1:0]; // fits in 32 bits
		end else if (acc_out[ACC_W-1]) begin
			res_sat = {1'b1, {(SAT_W-1){1'b0}}}; // clamp low
		end else begin
			res_sat = {1'b0, {(SAT_W-1){1'b1}}}; // clamp high
		end
	end

endmodule

// File: rtl/mac_unit.sv
// ################################################
// multiply-accumulate unit of the soft-core CPU
// decode, MAC pipeline and result stage, one strobe per command
// ################################################

module mac_unit import mac_pkg::*; #(
	parameter int INPUT_REG = 1,
	parameter int MUL_REG   = 1
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cmd_valid,
	input  mac_op_t           cmd_op,
	input  logic [OPER_W-1:0] cmd_a,
	input  logic [OPER_W-1:0] cmd_b,
	input  logic [TAG_W-1:0]  cmd_tag,
	output logic              res_valid,
	output logic [TAG_W-1:0]  res_tag,
	output logic [ACC_W-1:0]  res_acc,
	output logic [SAT_W-1:0]  res_sat
);

	logic [MUL_W-1:0] mul_a;
	logic [MUL_W-1:0] mul_b;
	logic [ACC_W-1:0] addend;
	post_sel_t        post_sel;
	logic             sub;
	logic             acc_en;
	logic [ACC_W-1:0] acc_out;

	mac_op_decode decode0 (
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_a     (cmd_a),
		.cmd_b     (cmd_b),
		.mul_a     (mul_a),
		.mul_b     (mul_b),
		.addend    (addend),
		.post_sel  (post_sel),
		.sub       (sub),
		.acc_en    (acc_en)
	);

	mac16x16 #(
		.INPUT_REG (INPUT_REG),
		.MUL_REG   (MUL_REG)
	) mac0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.acc_en   (acc_en),
		.mul_a    (mul_a),
		.mul_b    (mul_b),
		.addend   (addend),
		.post_sel (post_sel),
		.sub      (sub),
		.acc_out  (acc_out)
	);

	acc_result_stage #(
		.INPUT_REG (INPUT_REG),
		.MUL_REG   (MUL_REG)
	) result0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_tag   (cmd_tag),
		.acc_out   (acc_out),
		.res_valid (res_valid),
		.res_tag   (res_tag),
		.res_acc   (res_acc),
		.res_sat   (res_sat)
	);

endmodule

// File: bench/tb_mac_unit.sv
// ################################################
// testbench for mac_unit, reads golden command vectors,
// drives them with random idle gaps and checks every result
// ################################################

module tb_mac_unit import mac_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int INPUT_REG = 1;
	localparam int MUL_REG   = 1;
	localparam int LATENCY   = INPUT_REG + MUL_REG + 1; // command edge to res_valid

	logic              clk;
	logic              rst_n;
	logic              cmd_valid;
	mac_op_t           cmd_op;
	logic [OPER_W-1:0] cmd_a;
	logic [OPER_W-1:0] cmd_b;
	logic [TAG_W-1:0]  cmd_tag;
	logic              res_valid;
	logic [TAG_W-1:0]  res_tag;
	logic [ACC_W-1:0]  res_acc;
	logic [SAT_W-1:0]  res_sat;

	// one golden entry per command
	mac_op_t           op_v[$];
	logic [OPER_W-1:0] a_v[$];
	logic [OPER_W-1:0] b_v[$];
	logic [TAG_W-1:0]  tag_v[$];
	logic [ACC_W-1:0]  acc_v[$];
	logic [SAT_W-1:0]  sat_v[$];
	int                n_vec = 0;

	// vector index and issue cycle of commands in flight
	int idx_q[$];
	int issue_q[$];

	int cyc     = 0;    // posedges seen so far
	int checked = 0;
	int seed    = 1747;

	mac_unit dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_a     (cmd_a),
		.cmd_b     (cmd_b),
		.cmd_tag   (cmd_tag),
		.res_valid (res_valid),
		.res_tag   (res_tag),
		.res_acc   (res_acc),
		.res_sat   (res_sat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_tag(input logic [TAG_W-1:0] expected, input logic [TAG_W-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %t: res_tag expected 0x%h, got 0x%h",
				$time, expected, actual));
		end
	endtask

	task automatic check_acc(input logic [ACC_W-1:0] expected, input logic [ACC_W-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %t: res_acc expected 0x%h, got 0x%h",
				$time, expected, actual));
		end
	endtask

	task automatic check_sat(input logic [SAT_W-1:0] expected, input logic [SAT_W-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %t: res_sat expected 0x%h, got 0x%h",
				$time, expected, actual));
		end
	endtask

	// lines starting with # are column notes
	task automatic load_vectors();
		int                fd;
		int                n;
		string             line;
		logic [2:0]        op_raw;
		logic [OPER_W-1:0] a_raw;
		logic [OPER_W-1:0] b_raw;
		logic [TAG_W-1:0]  tag_raw;
		logic [ACC_W-1:0]  acc_raw;
		logic [SAT_W-1:0]  sat_raw;
		fd = $fopen("bench/mac_golden.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the golden vector file bench/mac_golden.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h",
						op_raw, a_raw, b_raw, tag_raw, acc_raw, sat_raw);
					if (n == 6 && op_raw <= 3'd5) begin
						op_v.push_back(mac_op_t'(op_raw));
						a_v.push_back(a_raw);
						b_v.push_back(b_raw);
						tag_v.push_back(tag_raw);
						acc_v.push_back(acc_raw);
						sat_v.push_back(sat_raw);
					end else if (n > 0) begin
						abort_run({"malformed line in golden vector file: ", line});
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_command(input int i);
		cmd_valid = 1'b1;
		cmd_op    = op_v[i];
		cmd_a     = a_v[i];
		cmd_b     = b_v[i];
		cmd_tag   = tag_v[i];
		idx_q.push_back(i);
		issue_q.push_back(cyc); // accepted on the next posedge
	endtask

	task automatic score_result();
		int idx;
		int issued;
		if (idx_q.size() == 0) begin
			abort_run("res_valid came while no command was in flight");
		end else begin
			idx    = idx_q.pop_front();
			issued = issue_q.pop_front();
			if (cyc != issued + LATENCY) begin
				abort_run($sformatf("result for command %0d came %0d cycles after it, not %0d",
					idx, cyc - issued, LATENCY));
			end
			check_tag(tag_v[idx], res_tag);
			check_acc(acc_v[idx], res_acc);
			check_sat(sat_v[idx], res_sat);
			checked++;
		end
	endtask

	// outputs sampled half a cycle after the posedge
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (res_valid === 1'b1) begin
				score_result();
			end else if (res_valid !== 1'b0) begin
				abort_run("res_valid is unknown after reset");
			end else if (issue_q.size() > 0 && cyc >= issue_q[0] + LATENCY) begin
				abort_run($sformatf("no result for command %0d after %0d cycles",
					idx_q[0], LATENCY));
			end
		end
	end

	initial begin : watchdog
		wait (n_vec > 0);
		repeat (n_vec * 4 + 50) @(posedge clk);
		abort_run("timeout, not all results came back in time");
	end

	initial begin : stimulus
		int gap;
		$timeformat(-9, 0, " ns", 0);
		rst_n     = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = OP_MUL_S;
		cmd_a     = '0;
		cmd_b     = '0;
		cmd_tag   = '0;
		load_vectors();
		if (op_v.size() == 0) begin
			abort_run("golden vector file holds no commands");
		end
		n_vec = op_v.size();
		repeat (4) @(posedge clk); // reset held over four posedges
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_vec; i++) begin
			// accumulate and subtract chains run back-to-back
			if (op_v[i] == OP_MAC_S || op_v[i] == OP_MSU_S) begin
				gap = 0;
			end else begin
				gap = $random(seed) % 3;
				if (gap < 0) begin
					gap = -gap;
				end
			end
			repeat (gap) begin
				cmd_valid = 1'b0;
				@(negedge clk);
			end
			drive_command(i);
			@(negedge clk);
		end
		cmd_valid = 1'b0;
		wait (checked == n_vec);
		repeat (LATENCY + 2) @(negedge clk); // catch stray strobes
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: bench/mac_golden.txt
# op a b tag exp_acc exp_sat, all hex, one command per row in issue order
# op: 0 mul_s, 1 mul_u, 2 mac_s, 3 mac_u, 4 msu_s, 5 load
2 0003 0004 0 00000000000c 0000000c
1 ffff ffff 1 0000fffe0001 7fffffff
0 ffff ffff 2 000000000001 00000001
0 8000 8000 3 000040000000 40000000
0 8000 7fff 4 ffffc0008000 c0008000
1 8000 7fff 5 00003fff8000 3fff8000
1 ffff 0001 6 00000000ffff 0000ffff
0 ffff 0001 7 ffffffffffff ffffffff
2 0100 0100 8 00000000ffff 0000ffff
2 1234 0010 9 00000002233f 0002233f
4 0002 0003 a 000000022339 00022339
2 fffe 0005 b 00000002232f 0002232f
4 fff0 0010 c 00000002242f 0002242f
2 7fff 7fff d 000040012430 40012430
5 1234 5678 e 000012345678 12345678
2 0002 0003 f 00001234567e 1234567e
3 ffff 0002 0 00001236567c 1236567c
5 ffff ff00 1 ffffffffff00 ffffff00
2 0010 0004 2 ffffffffff40 ffffff40
4 0003 0005 3 ffffffffff31 ffffff31
5 8000 0000 4 ffff80000000 80000000
4 0001 0001 5 ffff7fffffff 80000000
2 0001 0002 6 ffff80000001 80000001
5 7fff ffff 7 00007fffffff 7fffffff
3 0001 0001 8 000080000000 7fffffff
4 0001 0001 9 00007fffffff 7fffffff
2 7fff 7fff a 0000bfff0000 7fffffff
1 ffff ffff b 0000fffe0001 7fffffff
3 ffff ffff c 0001fffc0002 7fffffff
3 ffff ffff d 0002fffa0003 7fffffff
3 ffff ffff e 0003fff80004 7fffffff
4 7fff 8000 f 00043ff78004 7fffffff
0 8000 7fff 0 ffffc0008000 c0008000
4 7fff 7fff 1 ffff80017fff 80017fff
4 7fff 7fff 2 ffff40027ffe 80000000
2 8000 8000 3 ffff80027ffe 80027ffe
5 ffff ffff 4 ffffffffffff ffffffff
3 0001 0001 5 000000000000 00000000
4 0001 0001 6 ffffffffffff ffffffff
3 ffff ffff 7 0000fffe0000 7fffffff

// File: verilog.f
rtl/mac_pkg.sv
rtl/mac_op_decode.sv
rtl/mac16x16.sv
rtl/acc_result_stage.sv
rtl/mac_unit.sv
bench/tb_mac_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mac_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -j 0 \
	--top-module tb_mac_unit \
	-f verilog.f \
	-o sim_mac_unit

# the pipe keeps going on a failed run, the log decides
./obj_dir/sim_mac_unit | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation finished, see sim.log"
exit 0
